// ==== all.f ====
+incdir+rtl
rtl/mem_pkg.sv
rtl/host_pkg.sv
rtl/prog_loader.sv
rtl/mem_ctrl.sv
rtl/rom_fetch.sv
rtl/core_top.sv
verif/mem_assertions.sv
verif/tb_top.sv

// ==== rtl/core_top.sv ====
`timescale 1ns/1ps
`include "frame_params.svh"

module core_top
    import mem_pkg::*, host_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   downloading,
    input  logic   dl_stb,
    input  dl_wr_t dl,
    output logic   dwnld_busy,
    input  logic   fetch_stb   [`FRAME_BANKS],
    input  waddr_t fetch_addr  [`FRAME_BANKS],
    output logic   fetch_valid [`FRAME_BANKS],
    output word_t  fetch_data  [`FRAME_BANKS]
);

    logic     prog_stb;
    prog_wr_t prog;
    logic     prog_en;   // Blocks game reads
    rd_req_t  rd_req [`FRAME_BANKS];
    rd_rsp_t  rd_rsp [`FRAME_BANKS];

    prog_loader u_loader (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .dl_stb      (dl_stb),
        .dl          (dl),
        .prog_stb    (prog_stb),
        .prog        (prog),
        .dwnld_busy  (dwnld_busy),
        .prog_en     (prog_en)
    );

    mem_ctrl u_mem (
        .clk      (clk),
        .reset    (reset),
        .prog_en  (prog_en),
        .prog_stb (prog_stb),
        .prog     (prog),
        .rd_req   (rd_req),
        .rd_rsp   (rd_rsp)
    );

    // One fetch unit per bank
    for (genvar b = 0; b < `FRAME_BANKS; b++) begin : g_fetch
        rom_fetch u_fetch (
            .clk         (clk),
            .reset       (reset),
            .fetch_stb   (fetch_stb[b]),
            .fetch_addr  (fetch_addr[b]),
            .rd_req      (rd_req[b]),
            .rd_rsp      (rd_rsp[b]),
            .fetch_valid (fetch_valid[b]),
            .fetch_data  (fetch_data[b])
        );
    end

endmodule

// ==== rtl/frame_params.svh ====
`ifndef FRAME_PARAMS_SVH
`define FRAME_PARAMS_SVH

// Word address width inside one bank
`define FRAME_AW 10

// Banks behind the memory controller
`define FRAME_BANKS 2

// Cycles from read ack to dok
`define FRAME_RD_LAT 3

`endif

// ==== rtl/host_pkg.sv ====
`include "frame_params.svh"

package host_pkg;

    typedef logic [7:0] dl_byte_t;

    // Top bit selects the bank, bit 0 the byte lane
    typedef logic [`FRAME_AW+1:0] dl_addr_t;

    // Carried by the download strobe
    typedef struct packed {
        dl_addr_t addr;
        dl_byte_t data;
    } dl_wr_t;

endpackage

// ==== rtl/mem_ctrl.sv ====
`timescale 1ns/1ps
`include "frame_params.svh"

module mem_ctrl
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     prog_en,
    input  logic     prog_stb,
    input  prog_wr_t prog,
    input  rd_req_t  rd_req [`FRAME_BANKS],
    output rd_rsp_t  rd_rsp [`FRAME_BANKS]
);

    typedef struct packed {
        bank_t bank;
        word_t data;
    } lat_stage_t;

    word_t mem [`FRAME_BANKS][2**`FRAME_AW];

    logic [`FRAME_BANKS-1:0] pend;
    logic [`FRAME_BANKS-1:0] ack_q;
    logic                    gnt_any;
    bank_t                   gnt_bank;
    bank_t                   gnt_bank_q;
    bank_t                   rr_ptr;
    bank_t                   cand;

    logic [`FRAME_RD_LAT-1:0] vld_pipe;
    lat_stage_t               pipe [`FRAME_RD_LAT];

    // Program writes always win, byte by byte
    always_ff @(posedge clk) begin
        if (prog_stb) begin
            if (!prog.mask[0]) begin
                mem[prog.bank][prog.addr][7:0] <= prog.data[7:0];
            end
            if (!prog.mask[1]) begin
                mem[prog.bank][prog.addr][15:8] <= prog.data[15:8];
            end
        end
    end

    // A bank acked last cycle still shows rd high now
    always_comb begin
        for (int b = 0; b < `FRAME_BANKS; b++) begin
            pend[b] = rd_req[b].rd & ~ack_q[b];
        end
    end

    always_comb begin
        gnt_any  = 1'b0;
        gnt_bank = rr_ptr;
        cand     = rr_ptr;
        for (int i = 0; i < `FRAME_BANKS; i++) begin
            cand = bank_t'(rr_ptr + bank_t'(i));   // Start at the pointer
            if (!gnt_any && pend[cand]) begin
                gnt_any  = 1'b1;
                gnt_bank = cand;
            end
        end
        if (prog_en) begin
            gnt_any = 1'b0;   // No reads during download
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q  <= '0;
            rr_ptr <= '0;
        end else begin
            ack_q <= '0;
            if (gnt_any) begin
                ack_q[gnt_bank] <= 1'b1;
                rr_ptr          <= gnt_bank + 1'b1;   // Other bank first next time
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gnt_any) begin
            gnt_bank_q <= gnt_bank;
        end
    end

    // Latency pipe, loaded in the ack cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[`FRAME_RD_LAT-2:0], |ack_q};
        end
    end

    always_ff @(posedge clk) begin
        pipe[0].bank <= gnt_bank_q;
        pipe[0].data <= mem[gnt_bank_q][rd_req[gnt_bank_q].addr];
        for (int i = 1; i < `FRAME_RD_LAT; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

    always_comb begin
        for (int b = 0; b < `FRAME_BANKS; b++) begin
            rd_rsp[b].ack  = ack_q[b];
            rd_rsp[b].dok  = vld_pipe[`FRAME_RD_LAT-1]
                             & (pipe[`FRAME_RD_LAT-1].bank == bank_t'(b));
            rd_rsp[b].data = pipe[`FRAME_RD_LAT-1].data;
        end
    end

endmodule

// ==== rtl/mem_pkg.sv ====
`include "frame_params.svh"

package mem_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  mask_t;   // Set bit keeps that byte
    typedef logic [0:0]  bank_t;
    typedef logic [`FRAME_AW-1:0] waddr_t;

    // One program write from the loader
    typedef struct packed {
        bank_t  bank;
        waddr_t addr;
        word_t  data;
        mask_t  mask;
    } prog_wr_t;

    typedef struct packed {
        logic   rd;       // Held until ack
        waddr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic  ack;
        logic  dok;       // Data valid strobe
        word_t data;
    } rd_rsp_t;

endpackage

// ==== rtl/prog_loader.sv ====
`timescale 1ns/1ps
`include "frame_params.svh"

module prog_loader
    import mem_pkg::*, host_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     downloading,
    input  logic     dl_stb,
    input  dl_wr_t   dl,
    output logic     prog_stb,
    output prog_wr_t prog,
    output logic     dwnld_busy,
    output logic     prog_en
);

    logic busy_q;   // Covers the write still in flight

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_stb <= 1'b0;
            busy_q   <= 1'b0;
        end else begin
            prog_stb <= dl_stb;
            busy_q   <= downloading | dl_stb;
        end
    end

    // Byte lands in both lanes and the mask picks one
    always_ff @(posedge clk) begin
        if (dl_stb) begin
            prog.bank <= dl.addr[`FRAME_AW+1];
            prog.addr <= dl.addr[`FRAME_AW:1];
            prog.data <= {2{dl.data}};
            if (dl.addr[0]) begin
                prog.mask <= 2'b01;   // Odd byte goes high
            end else begin
                prog.mask <= 2'b10;
            end
        end
    end

    // Falls one cycle after downloading once nothing is pending
    assign dwnld_busy = downloading | busy_q;

    // Same gating term the game side sees on the real frame
    assign prog_en = downloading | dwnld_busy;

endmodule

// ==== rtl/rom_fetch.sv ====
`timescale 1ns/1ps

module rom_fetch
    import mem_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    fetch_stb,
    input  waddr_t  fetch_addr,
    output rd_req_t rd_req,
    input  rd_rsp_t rd_rsp,
    output logic    fetch_valid,
    output word_t   fetch_data
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,    // rd held high
        S_WAIT    // Acked, waiting for dok
    } fetch_state_t;

    fetch_state_t state;
    waddr_t       addr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= S_IDLE;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b0;
            case (state)
                S_IDLE: if (fetch_stb) state <= S_REQ;
                S_REQ:  if (rd_rsp.ack) state <= S_WAIT;
                S_WAIT: begin
                    if (rd_rsp.dok) begin
                        state       <= S_IDLE;
                        fetch_valid <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Strobes while busy are dropped
    always_ff @(posedge clk) begin
        if (state == S_IDLE && fetch_stb) begin
            addr_q <= fetch_addr;
        end
        if (state == S_WAIT && rd_rsp.dok) begin
            fetch_data <= rd_rsp.data;
        end
    end

    assign rd_req.rd   = (state == S_REQ);
    assign rd_req.addr = addr_q;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then scan the log for the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module tb_top -Mdir obj_dir -o sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "Simulation ended without a pass line"; exit 1; }
echo "Simulation passed"
exit 0

// ==== verif/mem_assertions.sv ====
`timescale 1ns/1ps
`include "frame_params.svh"

module mem_assertions
    import mem_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input logic    prog_en,
    input logic    prog_stb,
    input rd_req_t rd_req [`FRAME_BANKS],
    input rd_rsp_t rd_rsp [`FRAME_BANKS]
);

    logic [`FRAME_BANKS-1:0] ack_vec;
    logic [`FRAME_BANKS-1:0] dok_vec;
    logic [`FRAME_BANKS-1:0] rd_vec;

    always_comb begin
        for (int b = 0; b < `FRAME_BANKS; b++) begin
            ack_vec[b] = rd_rsp[b].ack;
            dok_vec[b] = rd_rsp[b].dok;
            rd_vec[b]  = rd_req[b].rd;
        end
    end

    // Game reads stay off the memory during a download
    ack_blocked_in_prog: assert property (@(posedge clk) disable iff (reset)
        |ack_vec |-> !prog_en)
        else $error("Read acknowledged while prog_en is high");

    // The acked bank still holds rd in its ack cycle
    ack_single: assert property (@(posedge clk) disable iff (reset)
        $onehot0(ack_vec) && ((ack_vec & ~rd_vec) == '0))
        else $error("More than one read acknowledged in a cycle, or an ack without rd");

    // Per bank, dok is exactly the ack delayed by the read latency
    dok_latency: assert property (@(posedge clk) disable iff (reset)
        dok_vec == $past(ack_vec, `FRAME_RD_LAT))
        else $error("dok does not follow ack by the read latency");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (ack_vec == '0) && (dok_vec == '0) && (rd_vec == '0) && !prog_stb)
        else $error("Handshake outputs active in the first cycle after reset");

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps
`include "frame_params.svh"

module tb_top
    import mem_pkg::*, host_pkg::*;
();

    localparam int BYTE_TOTAL   = 2 ** (`FRAME_AW + 2);   // Both banks
    localparam int WORD_TOTAL   = 2 ** `FRAME_AW;
    localparam int SEQ_FETCHES  = 64;
    localparam int REGION_WORDS = 16;
    localparam int PAIR_ROUNDS  = 100;
    localparam int BYTE_CYCLES  = 3;    // Strobe plus two idle cycles
    localparam int WORST_LAT    = 16;   // Strobe to fetch_valid under contention
    localparam int BYTE_COUNT   = BYTE_TOTAL + REGION_WORDS + 2;
    localparam int FETCH_COUNT  = 2 * SEQ_FETCHES + REGION_WORDS + 2 * PAIR_ROUNDS + 1;
    localparam int LIMIT_CYCLES = 2 * (50 + BYTE_COUNT * BYTE_CYCLES + FETCH_COUNT * WORST_LAT);

    logic   clk;
    logic   reset;
    logic   downloading;
    logic   dl_stb;
    dl_wr_t dl;
    logic   dwnld_busy;
    logic   fetch_stb   [`FRAME_BANKS];
    waddr_t fetch_addr  [`FRAME_BANKS];
    logic   fetch_valid [`FRAME_BANKS];
    word_t  fetch_data  [`FRAME_BANKS];

    dl_byte_t image [BYTE_TOTAL];   // Bytes the host has sent
    word_t    exp_q0 [$];
    word_t    exp_q1 [$];

    core_top uut (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .dl_stb      (dl_stb),
        .dl          (dl),
        .dwnld_busy  (dwnld_busy),
        .fetch_stb   (fetch_stb),
        .fetch_addr  (fetch_addr),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data)
    );

    bind mem_ctrl mem_assertions u_mem_asrt (
        .clk      (clk),
        .reset    (reset),
        .prog_en  (prog_en),
        .prog_stb (prog_stb),
        .rd_req   (rd_req),
        .rd_rsp   (rd_rsp)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, want);
            abort_run("Value check failed");
        end
    endtask

    // Odd byte sits in the high lane
    function automatic word_t ref_word(input bank_t bank, input waddr_t addr);
        dl_addr_t lo_a;
        dl_addr_t hi_a;
        lo_a = {bank, addr, 1'b0};
        hi_a = {bank, addr, 1'b1};
        return {image[hi_a], image[lo_a]};
    endfunction

    function automatic void push_expected(input bank_t b, input word_t w);
        if (b == 1'b0) begin
            exp_q0.push_back(w);
        end else begin
            exp_q1.push_back(w);
        end
    endfunction

    task automatic send_byte(input dl_addr_t a, input dl_byte_t d);
        @(negedge clk);
        dl_stb  = 1'b1;
        dl.addr = a;
        dl.data = d;
        image[a] = d;
        @(negedge clk);
        dl_stb = 1'b0;
        @(negedge clk);
    endtask

    task automatic start_download();
        @(negedge clk);
        downloading = 1'b1;
    endtask

    // Busy must drop exactly one cycle after downloading
    task automatic end_download();
        @(negedge clk);
        check("dwnld_busy", {15'b0, dwnld_busy}, 16'h0001);
        downloading = 1'b0;
        @(negedge clk);
        check("dwnld_busy", {15'b0, dwnld_busy}, 16'h0000);
    endtask

    task automatic start_fetch(input bank_t b, input waddr_t a);
        @(negedge clk);
        fetch_stb[b]  = 1'b1;
        fetch_addr[b] = a;
        push_expected(b, ref_word(b, a));
        @(negedge clk);
        fetch_stb[b] = 1'b0;
    endtask

    task automatic start_pair(input waddr_t a0, input waddr_t a1);
        @(negedge clk);
        fetch_stb[0]  = 1'b1;
        fetch_addr[0] = a0;
        fetch_stb[1]  = 1'b1;
        fetch_addr[1] = a1;
        push_expected(1'b0, ref_word(1'b0, a0));
        push_expected(1'b1, ref_word(1'b1, a1));
        @(negedge clk);
        fetch_stb[1]  = 1'b0;
        fetch_addr[0] = ~a0;   // Unit 0 is busy so this strobe is dropped
        @(negedge clk);
        fetch_stb[0] = 1'b0;
    endtask

    task automatic wait_fetches();
        while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check("dwnld_busy", {15'b0, dwnld_busy}, 16'h0000);
            check("fetch_valid[0]", {15'b0, fetch_valid[0]}, 16'h0000);
            check("fetch_valid[1]", {15'b0, fetch_valid[1]}, 16'h0000);
        end
    endtask

    task automatic take_result(input bank_t b);
        word_t want;
        int    depth;
        if (fetch_valid[b]) begin
            depth = (b == 1'b0) ? exp_q0.size() : exp_q1.size();
            if (dwnld_busy) begin
                abort_run($sformatf("Bank %0d returned data while the download was busy", b));
            end else if (depth == 0) begin
                abort_run($sformatf("Bank %0d returned data with no fetch outstanding", b));
            end else begin
                if (b == 1'b0) begin
                    want = exp_q0.pop_front();
                end else begin
                    want = exp_q1.pop_front();
                end
                check($sformatf("fetch_data[%0d]", b), fetch_data[b], want);
            end
        end
    endtask

    // Compare side, outputs settled by the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            for (int b = 0; b < `FRAME_BANKS; b++) begin
                take_result(bank_t'(b));
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        abort_run("Watchdog expired before the test sequence finished");
    end

    initial begin
        dl_addr_t a;
        waddr_t   w;
        waddr_t   base;
        dl_byte_t lo_b;
        dl_byte_t hi_b;

        clk         = 1'b0;
        reset       = 1'b1;
        downloading = 1'b0;
        dl_stb      = 1'b0;
        dl          = '0;
        fetch_stb   = '{default: 1'b0};
        fetch_addr  = '{default: '0};
        void'($urandom(32'h339ed28b));
        repeat (10) @(negedge clk);
        reset = 1'b0;

        idle_check(20);

        // Full image, then single fetches alternating banks
        start_download();
        for (int i = 0; i < BYTE_TOTAL; i++) begin
            send_byte(dl_addr_t'(i), dl_byte_t'($urandom));
        end
        end_download();
        for (int i = 0; i < 2 * SEQ_FETCHES; i++) begin
            start_fetch(bank_t'(i % 2), waddr_t'($urandom));
            wait_fetches();
        end

        // Odd bytes only, low lanes must survive
        base = waddr_t'($urandom % (WORD_TOTAL - REGION_WORDS));
        start_download();
        for (int i = 0; i < REGION_WORDS; i++) begin
            a = {1'b0, base + waddr_t'(i), 1'b1};
            send_byte(a, ~image[a]);
        end
        end_download();
        for (int i = 0; i < REGION_WORDS; i++) begin
            start_fetch(1'b0, base + waddr_t'(i));
            wait_fetches();
        end

        for (int i = 0; i < PAIR_ROUNDS; i++) begin
            start_pair(waddr_t'($urandom), waddr_t'($urandom));
            wait_fetches();
        end

        // Fetch held off by a download that rewrites its word
        w    = waddr_t'($urandom);
        lo_b = dl_byte_t'($urandom);
        hi_b = dl_byte_t'($urandom);
        image[{1'b1, w, 1'b0}] = lo_b;
        image[{1'b1, w, 1'b1}] = hi_b;
        start_download();
        start_fetch(1'b1, w);
        send_byte({1'b1, w, 1'b0}, lo_b);
        send_byte({1'b1, w, 1'b1}, hi_b);
        end_download();
        wait_fetches();

        repeat (5) @(negedge clk);
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            abort_run("Fetch results missing at the end of the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
